//--- kitchen_defines.svh
`ifndef KITCHEN_DEFINES_SVH
`define KITCHEN_DEFINES_SVH

////////////////////////////////////////
// kitchen size
////////////////////////////////////////
`define GRID_ROWS 8
`define GRID_COLS 13

////////////////////////////////////////
// long counts, simulation sized
// board values: debounce 1000000, scan 100000,
// tick 25000000, round 60
////////////////////////////////////////
`define DEBOUNCE_CYCLES 4
`define SCAN_CYCLES 8
`define TICK_CYCLES 2000
`define ROUND_TIME 20

// gameplay
`define CHOPS_NEEDED 3
`define POINTS_PER_ORDER 10

`endif

//--- kitchen_pkg.sv
package kitchen_pkg;

   ////////////////////////////////////////
   // enums
   ////////////////////////////////////////
   typedef enum logic [1:0] {
      STATE_PLAYING = 2'd0,
      STATE_PAUSED  = 2'd1,
      STATE_OVER    = 2'd2
   } game_state_t;

   typedef enum logic [1:0] {
      DIR_UP    = 2'd0,
      DIR_DOWN  = 2'd1,
      DIR_LEFT  = 2'd2,
      DIR_RIGHT = 2'd3
   } dir_t;

   typedef enum logic [1:0] {
      ITEM_NONE    = 2'd0,
      ITEM_RAW     = 2'd1, // raw onion
      ITEM_CHOPPED = 2'd2  // ready to serve
   } item_t;

   typedef enum logic [2:0] {
      TILE_FLOOR   = 3'd0,
      TILE_COUNTER = 3'd1,
      TILE_CRATE   = 3'd2,
      TILE_BOARD   = 3'd3, // chop board
      TILE_SERVE   = 3'd4
   } tile_t;

   typedef enum logic [2:0] {
      OP_LEFT  = 3'd0,
      OP_RIGHT = 3'd1,
      OP_UP    = 3'd2,
      OP_DOWN  = 3'd3,
      OP_CHOP  = 3'd4,
      OP_PICK  = 3'd5,
      OP_DROP  = 3'd6
   } cmd_op_t;

   ////////////////////////////////////////
   // structs
   ////////////////////////////////////////
   typedef struct packed {
      logic left;
      logic right;
      logic up;
      logic down;
      logic chop;
   } buttons_t;

   typedef struct packed {
      logic    valid;
      cmd_op_t op;
   } cmd_t;

   typedef struct packed {
      logic [3:0] x;    // column
      logic [2:0] y;    // row, 0 at the top
      dir_t       dir;
      item_t      held;
   } player_t;

   typedef struct packed {
      game_state_t state;
      logic [7:0]  time_left; // seconds
      logic [11:0] score;
      logic [3:0]  orders;
      player_t     player;
   } status_t;

endpackage

//--- button_debounce.sv
`include "kitchen_defines.svh"

module button_debounce (
   input  logic       clk_in,
   input  logic       reset_in,
   input  logic [5:0] noisy,
   output logic [5:0] clean
);

   localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

   logic [5:0]            sample; // last raw level seen per channel
   logic [5:0][CNT_W-1:0] count;  // cycles that level has held

   // each channel restarts its count whenever the raw level moves,
   // and only passes the level on once it has sat still long enough
   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         sample <= noisy;
         clean  <= noisy; // start at the pin level, no edge out of reset
         count  <= '0;
      end else begin
         for (int i = 0; i < 6; i++) begin
            if (noisy[i] != sample[i]) begin
               sample[i] <= noisy[i];
               count[i]  <= '0;
            end else if (count[i] == CNT_W'(`DEBOUNCE_CYCLES)) begin
               clean[i] <= sample[i];
            end else begin
               count[i] <= count[i] + 1'b1;
            end
         end
      end
   end

endmodule

//--- input_decode.sv
module input_decode (
   input  logic                     clk_in,
   input  logic                     reset_in,
   input  logic [5:0]               clean,
   input  kitchen_pkg::game_state_t state,
   output kitchen_pkg::cmd_t        cmd
);

   import kitchen_pkg::*;

   logic [5:0] clean_q;  // previous cycle
   logic [5:0] rise;
   logic [5:0] fall;
   buttons_t   btn_rise;
   logic       next_valid;
   cmd_op_t    next_op;

   // bit 5 is carry, bits 4..0 are the buttons struct
   assign rise     = clean & ~clean_q;
   assign fall     = ~clean & clean_q;
   assign btn_rise = buttons_t'(rise[4:0]);

   ////////////////////////////////////////
   // priority pick, one command per cycle
   ////////////////////////////////////////
   always_comb begin
      next_valid = 1'b1;
      next_op    = OP_DROP;
      if (fall[5]) begin
         next_op = OP_DROP;      // carry released
      end else if (rise[5]) begin
         next_op = OP_PICK;
      end else if (btn_rise.chop) begin
         next_op = OP_CHOP;
      end else if (btn_rise.up) begin
         next_op = OP_UP;
      end else if (btn_rise.down) begin
         next_op = OP_DOWN;
      end else if (btn_rise.left) begin
         next_op = OP_LEFT;
      end else if (btn_rise.right) begin
         next_op = OP_RIGHT;
      end else begin
         next_valid = 1'b0;
      end
      // nothing gets through unless the round is running
      if (state != STATE_PLAYING) next_valid = 1'b0;
   end

   always_ff @(posedge clk_in) begin
      clean_q <= clean;
      cmd.op  <= next_op; // only looked at with valid
      if (reset_in) begin
         cmd.valid <= 1'b0;
      end else begin
         cmd.valid <= next_valid;
      end
   end

endmodule

//--- kitchen_execute.sv
`include "kitchen_defines.svh"

module kitchen_execute (
   input  logic                 clk_in,
   input  logic                 reset_in,
   input  kitchen_pkg::cmd_t    cmd,
   output kitchen_pkg::player_t player,
   output logic                 served
);

   import kitchen_pkg::*;

   // fixed layout landmarks
   localparam logic [3:0] CRATE_X = 4'd6;
   localparam logic [2:0] CRATE_Y = 3'd0;
   localparam logic [3:0] BOARD_X = 4'd0;
   localparam logic [2:0] BOARD_Y = 3'd4;
   localparam logic [3:0] SERVE_X = 4'd12;
   localparam logic [2:0] SERVE_Y = 3'd4;
   localparam logic [3:0] START_X = 4'd6;
   localparam logic [2:0] START_Y = 3'd4;
   localparam int         CHOP_W  = $clog2(`CHOPS_NEEDED + 1);

   item_t             grid [`GRID_ROWS][`GRID_COLS]; // what sits on each cell
   logic [CHOP_W-1:0] chop_cnt;
   logic [CHOP_W-1:0] chop_next;
   player_t           player_next;
   logic              served_next;
   logic              wr_en;      // grid write, always at the faced cell
   item_t             wr_item;
   dir_t              look_dir;
   logic [3:0]        tgt_x;
   logic [2:0]        tgt_y;
   tile_t             tgt_tile;
   item_t             tgt_item;

   function automatic tile_t tile_at(input logic [3:0] x, input logic [2:0] y);
      tile_t t;
      if (x == CRATE_X && y == CRATE_Y) t = TILE_CRATE;
      else if (x == BOARD_X && y == BOARD_Y) t = TILE_BOARD;
      else if (x == SERVE_X && y == SERVE_Y) t = TILE_SERVE;
      else if (x == 4'd0 || x == 4'(`GRID_COLS - 1) ||
               y == 3'd0 || y == 3'(`GRID_ROWS - 1)) t = TILE_COUNTER;
      else t = TILE_FLOOR;
      return t;
   endfunction

   ////////////////////////////////////////
   // which cell the player looks at
   ////////////////////////////////////////
   always_comb begin
      look_dir = player.dir;
      if (cmd.valid) begin
         case (cmd.op)
            OP_LEFT:  look_dir = DIR_LEFT;  // a move turns first
            OP_RIGHT: look_dir = DIR_RIGHT;
            OP_UP:    look_dir = DIR_UP;
            OP_DOWN:  look_dir = DIR_DOWN;
            default:  look_dir = player.dir;
         endcase
      end
   end

   always_comb begin
      tgt_x = player.x;
      tgt_y = player.y;
      case (look_dir)
         DIR_UP:   tgt_y = player.y - 3'd1;
         DIR_DOWN: tgt_y = player.y + 3'd1;
         DIR_LEFT: tgt_x = player.x - 4'd1;
         default:  tgt_x = player.x + 4'd1;
      endcase
   end

   assign tgt_tile = tile_at(tgt_x, tgt_y);
   assign tgt_item = grid[tgt_y][tgt_x];

   ////////////////////////////////////////
   // command rules
   ////////////////////////////////////////
   always_comb begin
      player_next = player;
      chop_next   = chop_cnt;
      served_next = 1'b0;
      wr_en       = 1'b0;
      wr_item     = ITEM_NONE;
      if (cmd.valid) begin
         case (cmd.op)
            OP_LEFT, OP_RIGHT, OP_UP, OP_DOWN: begin
               player_next.dir = look_dir;
               if (tgt_tile == TILE_FLOOR) begin // counters block
                  player_next.x = tgt_x;
                  player_next.y = tgt_y;
               end
            end
            OP_PICK: begin
               if (player.held == ITEM_NONE) begin
                  if (tgt_tile == TILE_CRATE) begin
                     player_next.held = ITEM_RAW; // endless supply
                  end else if ((tgt_tile == TILE_COUNTER || tgt_tile == TILE_BOARD) &&
                               tgt_item != ITEM_NONE) begin
                     player_next.held = tgt_item;
                     wr_en            = 1'b1;     // cell emptied
                  end
               end
            end
            OP_DROP: begin
               if (player.held == ITEM_CHOPPED && tgt_tile == TILE_SERVE) begin
                  player_next.held = ITEM_NONE;
                  served_next      = 1'b1;
               end else if (player.held != ITEM_NONE && tgt_item == ITEM_NONE &&
                            (tgt_tile == TILE_COUNTER || tgt_tile == TILE_BOARD)) begin
                  player_next.held = ITEM_NONE;
                  wr_en            = 1'b1;
                  wr_item          = player.held;
               end
            end
            OP_CHOP: begin
               if (tgt_tile == TILE_BOARD && tgt_item == ITEM_RAW) begin
                  if (chop_cnt == CHOP_W'(`CHOPS_NEEDED - 1)) begin
                     wr_en     = 1'b1;
                     wr_item   = ITEM_CHOPPED;
                     chop_next = '0;
                  end else begin
                     chop_next = chop_cnt + 1'b1;
                  end
               end
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         player   <= '{x: START_X, y: START_Y, dir: DIR_UP, held: ITEM_NONE};
         chop_cnt <= '0;
         served   <= 1'b0;
         for (int r = 0; r < `GRID_ROWS; r++) begin
            for (int c = 0; c < `GRID_COLS; c++) begin
               grid[r][c] <= ITEM_NONE;
            end
         end
      end else begin
         player   <= player_next;
         chop_cnt <= chop_next;
         served   <= served_next; // one cycle pulse
         if (wr_en) grid[tgt_y][tgt_x] <= wr_item;
      end
   end

endmodule

//--- game_result.sv
`include "kitchen_defines.svh"

module game_result (
   input  logic                 clk_in,
   input  logic                 reset_in,
   input  logic                 pause,
   input  kitchen_pkg::player_t player,
   input  logic                 served,
   output kitchen_pkg::status_t status,
   output logic [31:0]          display
);

   import kitchen_pkg::*;

   localparam int TICK_W = $clog2(`TICK_CYCLES);

   logic [TICK_W-1:0] tick_cnt;
   logic              tick;       // one second gone
   game_state_t       state;
   game_state_t       state_next;
   logic [7:0]        time_left;
   logic [11:0]       score;
   logic [3:0]        orders;

   assign tick = (state == STATE_PLAYING) && (time_left != 8'd0) &&
                 (tick_cnt == TICK_W'(`TICK_CYCLES - 1));

   ////////////////////////////////////////
   // game state
   ////////////////////////////////////////
   always_comb begin
      if (state == STATE_OVER || time_left == 8'd0) begin
         state_next = STATE_OVER;       // sticky until reset
      end else if (pause) begin
         state_next = STATE_PAUSED;
      end else begin
         state_next = STATE_PLAYING;
      end
   end

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         state     <= STATE_PLAYING;
         tick_cnt  <= '0;
         time_left <= 8'(`ROUND_TIME);
         score     <= '0;
         orders    <= '0;
      end else begin
         state <= state_next;
         if (state == STATE_PLAYING) begin // clock frozen otherwise
            if (tick) begin
               tick_cnt  <= '0;
               time_left <= time_left - 8'd1;
            end else begin
               tick_cnt <= tick_cnt + 1'b1;
            end
         end
         if (served) begin
            score  <= score + 12'(`POINTS_PER_ORDER);
            orders <= orders + 4'd1;
         end
      end
   end

   assign status = '{state: state, time_left: time_left, score: score,
                     orders: orders, player: player};

   // digits left to right: time, score, orders, held item, state
   assign display = {time_left, score, orders, 2'b00, player.held, 2'b00, state};

endmodule

//--- seven_seg_scan.sv
`include "kitchen_defines.svh"

module seven_seg_scan (
   input  logic        clk_in,
   input  logic        reset_in,
   input  logic [31:0] value,
   output logic [6:0]  seg_cat,
   output logic [7:0]  seg_an
);

   localparam int SCAN_W = $clog2(`SCAN_CYCLES + 1);

   logic [SCAN_W-1:0] scan_cnt;
   logic [7:0]        digit_sel;  // one hot, bit 0 is the rightmost digit
   logic [3:0]        nibble;

   // segment bits are g..a, lit when 1
   function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
      logic [6:0] s;
      case (hex)
         4'h0: s = 7'h3f;
         4'h1: s = 7'h06;
         4'h2: s = 7'h5b;
         4'h3: s = 7'h4f;
         4'h4: s = 7'h66;
         4'h5: s = 7'h6d;
         4'h6: s = 7'h7d;
         4'h7: s = 7'h07;
         4'h8: s = 7'h7f;
         4'h9: s = 7'h6f;
         4'ha: s = 7'h77;
         4'hb: s = 7'h7c; // lower case b
         4'hc: s = 7'h39;
         4'hd: s = 7'h5e; // lower case d
         4'he: s = 7'h79;
         default: s = 7'h71;
      endcase
      return s;
   endfunction

   always_comb begin
      nibble = value[3:0];
      for (int i = 0; i < 8; i++) begin
         if (digit_sel[i]) nibble = value[i*4 +: 4];
      end
   end

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         scan_cnt  <= '0;
         digit_sel <= 8'b0000_0001;
      end else if (scan_cnt == SCAN_W'(`SCAN_CYCLES)) begin
         scan_cnt  <= '0;
         digit_sel <= {digit_sel[6:0], digit_sel[7]}; // next digit left
      end else begin
         scan_cnt <= scan_cnt + 1'b1;
      end
   end

   assign seg_cat = ~hex_to_seg(nibble); // board pins are active low
   assign seg_an  = ~digit_sel;

endmodule

//--- kitchen_top.sv
module kitchen_top (
   input  logic                  clk_in,
   input  logic                  reset_in,
   input  kitchen_pkg::buttons_t buttons,
   input  logic                  carry,
   input  logic                  pause,
   output kitchen_pkg::status_t  status,
   output logic [6:0]            seg_cat,
   output logic [7:0]            seg_an
);

   import kitchen_pkg::*;

   logic [5:0]  noisy;    // carry on top, buttons below
   logic [5:0]  clean;
   cmd_t        cmd;
   player_t     player;
   logic        served;
   logic [31:0] display;

   assign noisy = {carry, buttons};

   ////////////////////////////////////////
   // input side
   ////////////////////////////////////////
   button_debounce i_button_debounce (
      .clk_in   (clk_in),
      .reset_in (reset_in),
      .noisy    (noisy),
      .clean    (clean)
   );

   input_decode i_input_decode (
      .clk_in   (clk_in),
      .reset_in (reset_in),
      .clean    (clean),
      .state    (status.state), // closes the loop from game_result
      .cmd      (cmd)
   );

   ////////////////////////////////////////
   // game stages and display
   ////////////////////////////////////////
   kitchen_execute i_kitchen_execute (
      .clk_in   (clk_in),
      .reset_in (reset_in),
      .cmd      (cmd),
      .player   (player),
      .served   (served)
   );

   game_result i_game_result (
      .clk_in   (clk_in),
      .reset_in (reset_in),
      .pause    (pause),
      .player   (player),
      .served   (served),
      .status   (status),
      .display  (display)
   );

   seven_seg_scan i_seven_seg_scan (
      .clk_in   (clk_in),
      .reset_in (reset_in),
      .value    (display),
      .seg_cat  (seg_cat),
      .seg_an   (seg_an)
   );

endmodule

//--- tb_clock.sv
module tb_clock (
   output logic clk_in
);

   timeunit 1ns;
   timeprecision 100ps;

   initial clk_in = 1'b0;

   always #10 clk_in = ~clk_in; // 20 ns period

endmodule

//--- kitchen_tb.sv
`include "kitchen_defines.svh"

module kitchen_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import kitchen_pkg::*;

   localparam int HOLD_CYCLES = 2 * `DEBOUNCE_CYCLES + 4; // half a press
   localparam int MAX_PRESSES = 160;
   localparam int CYCLE_LIMIT = (`ROUND_TIME + 2) * `TICK_CYCLES +
                                MAX_PRESSES * 2 * HOLD_CYCLES + 1000;

   // lit segments g..a for hex 0 to F
   localparam logic [6:0] HEX_SEGS [16] = '{
      7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
      7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
   };

   logic        clk_in;
   logic        reset_in;
   buttons_t    buttons;
   logic        carry;
   logic        pause;
   status_t     status;
   logic [6:0]  seg_cat;
   logic [7:0]  seg_an;

   // reference model
   player_t     model_player;
   item_t       model_grid [`GRID_ROWS][`GRID_COLS];
   int          model_chops;
   logic [11:0] model_score;
   logic [3:0]  model_orders;
   game_state_t model_state;

   logic [16:0] lfsr;
   int          errors = 0;
   int          checks = 0;
   int          test_num = 0;
   int          tests_failed = 0;
   int          test_start_errors = 0;
   string       test_name;
   int          cycle_count = 0;
   event        check_ev;
   event        check_done_ev;

   tb_clock i_tb_clock (
      .clk_in (clk_in)
   );

   kitchen_top i_kitchen_top (
      .clk_in   (clk_in),
      .reset_in (reset_in),
      .buttons  (buttons),
      .carry    (carry),
      .pause    (pause),
      .status   (status),
      .seg_cat  (seg_cat),
      .seg_an   (seg_an)
   );

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic tile_t tile_of(input int x, input int y);
      if (x == 6 && y == 0) return TILE_CRATE;
      if (x == 0 && y == 4) return TILE_BOARD;
      if (x == 12 && y == 4) return TILE_SERVE;
      if (x == 0 || y == 0 || x == `GRID_COLS - 1 || y == `GRID_ROWS - 1) begin
         return TILE_COUNTER; // border ring
      end
      return TILE_FLOOR;
   endfunction

   task automatic model_reset();
      model_player = '{x: 4'd6, y: 3'd4, dir: DIR_UP, held: ITEM_NONE};
      model_chops  = 0;
      model_score  = '0;
      model_orders = '0;
      model_state  = STATE_PLAYING;
      for (int r = 0; r < `GRID_ROWS; r++) begin
         for (int c = 0; c < `GRID_COLS; c++) model_grid[r][c] = ITEM_NONE;
      end
   endtask

   function automatic void model_step(input cmd_op_t op);
      int    tx;
      int    ty;
      tile_t t;
      dir_t  d;
      if (model_state != STATE_PLAYING) return; // decode drops it
      d = model_player.dir;
      case (op)
         OP_LEFT:  d = DIR_LEFT;
         OP_RIGHT: d = DIR_RIGHT;
         OP_UP:    d = DIR_UP;
         OP_DOWN:  d = DIR_DOWN;
         default:  ;
      endcase
      tx = model_player.x;
      ty = model_player.y;
      case (d)
         DIR_UP:   ty = ty - 1;
         DIR_DOWN: ty = ty + 1;
         DIR_LEFT: tx = tx - 1;
         default:  tx = tx + 1;
      endcase
      t = tile_of(tx, ty);
      case (op)
         OP_LEFT, OP_RIGHT, OP_UP, OP_DOWN: begin
            model_player.dir = d;
            if (t == TILE_FLOOR) begin
               model_player.x = 4'(tx);
               model_player.y = 3'(ty);
            end
         end
         OP_PICK: begin
            if (model_player.held == ITEM_NONE) begin
               if (t == TILE_CRATE) begin
                  model_player.held = ITEM_RAW;
               end else if ((t == TILE_COUNTER || t == TILE_BOARD) &&
                            model_grid[ty][tx] != ITEM_NONE) begin
                  model_player.held  = model_grid[ty][tx];
                  model_grid[ty][tx] = ITEM_NONE;
               end
            end
         end
         OP_DROP: begin
            if (t == TILE_SERVE && model_player.held == ITEM_CHOPPED) begin
               model_player.held = ITEM_NONE;
               model_score       = model_score + 12'(`POINTS_PER_ORDER);
               model_orders      = model_orders + 4'd1;
            end else if (model_player.held != ITEM_NONE && model_grid[ty][tx] == ITEM_NONE &&
                         (t == TILE_COUNTER || t == TILE_BOARD)) begin
               model_grid[ty][tx] = model_player.held;
               model_player.held  = ITEM_NONE;
            end
         end
         default: begin // chop
            if (t == TILE_BOARD && model_grid[ty][tx] == ITEM_RAW) begin
               model_chops++;
               if (model_chops == `CHOPS_NEEDED) begin
                  model_grid[ty][tx] = ITEM_CHOPPED;
                  model_chops        = 0;
               end
            end
         end
      endcase
   endfunction

   // x^17 + x^14 + 1, new bit lands in bit 0
   function automatic logic [16:0] lfsr_step(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////
   task automatic report_error(input string msg);
      errors++;
      $display("Error at %0d ns: %s", $time, msg);
   endtask

   task automatic compare_player(input player_t got, input player_t exp);
      checks++;
      if (got != exp) begin
         report_error($sformatf("player x%0d y%0d %s %s, expected x%0d y%0d %s %s",
            got.x, got.y, got.dir.name(), got.held.name(),
            exp.x, exp.y, exp.dir.name(), exp.held.name()));
      end
   endtask

   task automatic compare_score(input status_t got, input status_t exp);
      checks++;
      if (got.score != exp.score || got.orders != exp.orders) begin
         report_error($sformatf("score %0d orders %0d, expected score %0d orders %0d",
            got.score, got.orders, exp.score, exp.orders));
      end
   endtask

   task automatic compare_state(input game_state_t got, input game_state_t exp);
      checks++;
      if (got != exp) report_error($sformatf("state %s, expected %s", got.name(), exp.name()));
   endtask

   task automatic compare_bits(input logic [7:0] got, input logic [7:0] exp, input string what);
      checks++;
      if (got != exp) report_error($sformatf("%s 0x%02h, expected 0x%02h", what, got, exp));
   endtask

   // checks all fields against the model at the next falling edge
   initial begin : compare_proc
      status_t exp;
      forever begin
         @(check_ev);
         @(negedge clk_in);
         exp        = '0;
         exp.score  = model_score;
         exp.orders = model_orders;
         compare_player(status.player, model_player);
         compare_score(status, exp);
         compare_state(status.state, model_state);
         -> check_done_ev;
      end
   end

   task automatic check_now();
      -> check_ev;
      @(check_done_ev);
   endtask

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////
   task automatic press_button(input cmd_op_t op);
      buttons_t b;
      b = '0;
      case (op)
         OP_LEFT:  b.left  = 1'b1;
         OP_RIGHT: b.right = 1'b1;
         OP_UP:    b.up    = 1'b1;
         OP_DOWN:  b.down  = 1'b1;
         default:  b.chop  = 1'b1;
      endcase
      @(posedge clk_in);
      buttons <= b;
      repeat (HOLD_CYCLES) @(posedge clk_in);
      buttons <= '0;
      repeat (HOLD_CYCLES) @(posedge clk_in);
      model_step(op);
      check_now();
   endtask

   task automatic set_carry(input logic level);
      @(posedge clk_in);
      carry <= level;
      repeat (HOLD_CYCLES) @(posedge clk_in);
      model_step(level ? OP_PICK : OP_DROP); // rising picks, falling drops
      check_now();
   endtask

   task automatic walk_to(input int tx, input int ty);
      while (model_player.x > tx) press_button(OP_LEFT);
      while (model_player.x < tx) press_button(OP_RIGHT);
      while (model_player.y > ty) press_button(OP_UP);
      while (model_player.y < ty) press_button(OP_DOWN);
   endtask

   task automatic run_order(input int chops);
      walk_to(6, 1);
      press_button(OP_UP);     // face the crate
      set_carry(1'b1);
      walk_to(1, 4);
      press_button(OP_LEFT);   // face the chop board
      set_carry(1'b0);
      repeat (chops) press_button(OP_CHOP);
      set_carry(1'b1);
      walk_to(11, 4);
      press_button(OP_RIGHT);  // serve window
      set_carry(1'b0);
   endtask

   task automatic start_test(input string name);
      test_num++;
      test_name         = name;
      test_start_errors = errors;
   endtask

   task automatic finish_test();
      if (errors == test_start_errors) begin
         $display("test %0d %s: ok", test_num, test_name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", test_num, test_name, errors - test_start_errors);
      end
   endtask

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////
   initial begin : stimulus
      logic [1:0]  rnd;
      logic [7:0]  frozen;
      logic [31:0] word;
      logic [7:0]  seen;
      int          digit;
      status_t     exp;
      reset_in = 1'b1;
      buttons  = '0;
      carry    = 1'b0;
      pause    = 1'b0;
      lfsr     = 17'd88608;
      model_reset();
      repeat (2) @(posedge clk_in);
      reset_in <= 1'b0;

      start_test("reset state");
      @(negedge clk_in);
      compare_bits(status.time_left, 8'(`ROUND_TIME), "time left");
      compare_bits(seg_an, 8'hfe, "digit select");
      check_now();
      finish_test();

      start_test("random moves");
      for (int i = 0; i < 30; i++) begin
         lfsr   = lfsr_step(lfsr);
         rnd[0] = lfsr[0];
         lfsr   = lfsr_step(lfsr);
         rnd[1] = lfsr[0];
         case (rnd)
            2'd0:    press_button(OP_LEFT);
            2'd1:    press_button(OP_RIGHT);
            2'd2:    press_button(OP_UP);
            default: press_button(OP_DOWN);
         endcase
      end
      finish_test();

      start_test("serve order");
      run_order(`CHOPS_NEEDED);
      exp        = '0;
      exp.score  = 12'(`POINTS_PER_ORDER);
      exp.orders = 4'd1;
      compare_score(status, exp);
      run_order(`CHOPS_NEEDED - 1); // still raw, window refuses it
      compare_score(status, exp);
      compare_bits(8'(status.player.held), 8'(ITEM_RAW), "held item");
      finish_test();

      start_test("pause");
      @(posedge clk_in);
      pause <= 1'b1;
      repeat (3) @(posedge clk_in);
      model_state = STATE_PAUSED;
      @(negedge clk_in);
      frozen = status.time_left;
      press_button(OP_UP);
      press_button(OP_RIGHT);
      repeat (`TICK_CYCLES) @(negedge clk_in); // longer than one second
      compare_bits(status.time_left, frozen, "time left while paused");
      @(posedge clk_in);
      pause <= 1'b0;
      repeat (3) @(posedge clk_in);
      model_state = STATE_PLAYING;
      press_button(OP_LEFT);
      press_button(OP_DOWN);
      finish_test();

      // paused so the time digits hold still during the scan
      start_test("display scan");
      @(posedge clk_in);
      pause <= 1'b1;
      repeat (3) @(posedge clk_in);
      model_state = STATE_PAUSED;
      @(negedge clk_in);
      frozen = status.time_left;
      word   = {frozen, model_score, model_orders, 2'b00, model_player.held,
                2'b00, model_state};
      seen   = '0;
      repeat (8 * (`SCAN_CYCLES + 1)) begin
         @(negedge clk_in);
         if ($countones(~seg_an) != 1) begin
            report_error("seg_an does not enable exactly one digit");
         end else begin
            digit = 0;
            for (int i = 0; i < 8; i++) begin
               if (!seg_an[i]) digit = i;
            end
            seen[digit] = 1'b1;
            compare_bits({1'b0, seg_cat}, {1'b0, ~HEX_SEGS[word[digit*4 +: 4]]},
                         $sformatf("seg_cat on digit %0d", digit));
         end
      end
      if (seen != 8'hff) report_error("the scan did not visit all eight digits");
      @(posedge clk_in);
      pause <= 1'b0;
      repeat (3) @(posedge clk_in);
      model_state = STATE_PLAYING;
      check_now();
      finish_test();

      start_test("round over");
      while (status.state != STATE_OVER) @(negedge clk_in);
      model_state = STATE_OVER;
      compare_bits(status.time_left, 8'd0, "time left at end");
      press_button(OP_UP);
      press_button(OP_LEFT);
      set_carry(1'b1);
      set_carry(1'b0);
      repeat (`TICK_CYCLES) @(negedge clk_in); // past one more second
      compare_bits(status.time_left, 8'd0, "time left after end");
      finish_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_num, tests_failed, checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   initial begin : watchdog
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk_in);
         cycle_count++;
      end
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
   end

endmodule

//--- flist.f
+incdir+.
kitchen_pkg.sv
button_debounce.sv
input_decode.sv
kitchen_execute.sv
game_result.sv
seven_seg_scan.sv
kitchen_top.sv
tb_clock.sv
kitchen_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the kitchen testbench with Verilator, run it, then search the log
verilator --binary --timing -Wno-fatal -f flist.f --top-module kitchen_tb -o kitchen_sim \
   && ./obj_dir/kitchen_sim > sim.log \
   ; cat sim.log \
   && grep -q ">>> PASS" sim.log \
   && ! grep -q ">>> FAIL" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
